// ==== src.f ====
+incdir+.
pd_pkg.sv
lfsr_bank.sv
lane_id_gen.sv
pd_sequencer.sv
pd_datapath.sv
pattern_detector.sv
pd_assertions.sv
tb_pattern_detector.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pattern detector testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_pattern_detector -f src.f -o sim_pd

./obj_dir/sim_pd | tee sim.log

grep -q "Simulation passed" sim.log

// ==== tb_pattern_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pd_defs.svh"

module tb_pattern_detector;
    import pd_pkg::*;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_req;
    pd_cmd_e   i_cmd;
    logic      i_beat_en;
    lanes_t    i_rx;
    logic      o_ack;
    lanes_t    o_rx;
    lanes_t    o_local;

    integer    seed;
    int        en_pct;        // Chance of a beat enable, percent
    int        tests;
    int        failed;
    int        errors;
    int        test_errors;
    beat_cnt_t beats;         // Beats seen inside the DUT

    // Reference model state
    lfsr_t      m_lfsr [`PD_LFSR_N];
    id_idx_t    m_idx;
    seq_state_e m_state;
    pd_cmd_e    m_cmd;
    beat_cnt_t  m_cnt;
    logic       m_ack;
    lanes_t     m_gen;
    lanes_t     m_local;
    lanes_t     m_rx;

    pattern_detector DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    function automatic lfsr_t lfsr_step(input lfsr_t s);
        return {s[21:0], s[22] ^ s[20] ^ s[15] ^ s[7] ^ s[4] ^ s[1]};
    endfunction

    function automatic lanes_t lfsr_lanes();
        lanes_t v;
        for (int n = 0; n < 16; n++) begin
            v[n] = m_lfsr[n % 8][22];  // Lanes n and n+8 share a generator
        end
        return v;
    endfunction

    // Framing nibbles around the bit-reversed lane number
    function automatic lanes_t id_lanes(input id_idx_t idx);
        lanes_t      v;
        logic [15:0] id;
        for (int n = 0; n < 16; n++) begin
            id = 16'hA00A;
            for (int b = 0; b < 8; b++) begin
                id[4 + b] = n[7 - b];
            end
            v[n] = id[idx];
        end
        return v;
    endfunction

    function automatic beat_cnt_t cmd_limit(input pd_cmd_e c);
        case (c)
            CMD_DESCRAMBLE: return beat_cnt_t'(`PD_DESCR_BEATS);
            CMD_LANE_ID:    return beat_cnt_t'(`PD_ID_BEATS);
            default:        return beat_cnt_t'(`PD_LFSR_BEATS);
        endcase
    endfunction

    task automatic seed_model();
        m_lfsr = '{`PD_SEED_0, `PD_SEED_1, `PD_SEED_2, `PD_SEED_3,
                   `PD_SEED_4, `PD_SEED_5, `PD_SEED_6, `PD_SEED_7};
        m_idx = '0;
    endtask

    // One clock edge of the model, using the inputs held before the edge
    task automatic model_edge();
        lanes_t    lb;
        lanes_t    ib;
        beat_cnt_t lim;
        logic      beat;
        logic      done;
        lb      = lfsr_lanes();
        ib      = id_lanes(m_idx);
        lim     = cmd_limit(m_cmd);
        beat    = (m_state == S_RUN) && i_beat_en && (m_cnt < lim);
        done    = (m_state == S_RUN) && i_beat_en && (m_cnt == lim);
        m_local = m_gen;
        m_rx    = (beat && m_cmd == CMD_DESCRAMBLE) ? (i_rx ^ lb) : i_rx;
        if (m_state != S_SEED && m_state != S_RUN) begin
            m_gen = '0;
        end else if (beat && m_cmd != CMD_DESCRAMBLE) begin
            m_gen = (m_cmd == CMD_LANE_ID) ? ib : lb;
        end
        if (beat) begin
            m_cnt = m_cnt + beat_cnt_t'(1);
            m_idx = (m_cmd == CMD_LANE_ID) ? m_idx + id_idx_t'(1) : m_idx;
            for (int i = 0; i < 8 && m_cmd != CMD_LANE_ID; i++) begin
                m_lfsr[i] = lfsr_step(m_lfsr[i]);
            end
        end
        case (m_state)
            S_IDLE: begin
                m_cmd   = i_req ? i_cmd : m_cmd;
                m_state = i_req ? S_SEED : S_IDLE;
            end
            S_SEED: begin
                seed_model();
                m_cnt   = '0;
                m_state = S_RUN;
            end
            S_RUN: begin
                if (done) begin
                    seed_model();  // Fresh seeds again at completion
                    m_ack   = 1'b1;
                    m_state = S_DONE;
                end
            end
            default: begin
                m_ack   = i_req;
                m_state = i_req ? S_DONE : S_IDLE;
            end
        endcase
    endtask

    task automatic check_lanes(input string name, input lanes_t got, input lanes_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_ack(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t o_ack got %b expected %b", $time, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_count(input beat_cnt_t got, input beat_cnt_t exp);
        if (got !== exp) begin
            $display("ERROR %0t beat count got %0d expected %0d", $time, got, exp);
            test_errors++;
        end
    endtask

    // Count DUT beats mid-cycle, step the model, check, then drive new inputs
    task automatic tick();
        @(negedge i_clk);
        if (DUT.ctrl.beat) begin
            beats++;
        end
        @(posedge i_clk);
        model_edge();
        #1;
        check_ack(o_ack, m_ack);
        check_lanes("o_rx", o_rx, m_rx);
        check_lanes("o_local", o_local, m_local);
        i_rx      = lanes_t'($random(seed));
        i_beat_en = ($unsigned($random(seed)) % 100) < en_pct;
    endtask

    task automatic run_cmd(input pd_cmd_e cmd, input int pct, input int hold);
        int n;
        en_pct = pct;
        beats  = '0;
        i_cmd  = cmd;
        i_req  = 1'b1;
        n      = 0;
        while (!o_ack && n < 20000) begin
            tick();
            n++;
        end
        if (!o_ack) begin
            $display("Timeout: o_ack did not rise within 20000 cycles");
            test_errors++;
        end
        check_count(beats, cmd_limit(cmd));
        repeat (hold) begin
            tick();
            check_ack(o_ack, 1'b1);  // Held while the request stays up
        end
        i_req = 1'b0;
        tick();
        check_ack(o_ack, 1'b0);
    endtask

    task automatic report(input string name);
        tests++;
        failed += (test_errors != 0) ? 1 : 0;
        errors += test_errors;
        $display("Test %0d %s: %s (%0d errors)", tests, name,
                 (test_errors == 0) ? "ok" : "FAILED", test_errors);
        test_errors = 0;
    endtask

    initial begin
        seed        = 32'h1818;
        en_pct      = 100;
        tests       = 0;
        failed      = 0;
        errors      = 0;
        test_errors = 0;
        beats       = '0;
        i_rst_n     = 1'b0;
        i_req       = 1'b0;
        i_cmd       = CMD_LFSR;
        i_beat_en   = 1'b0;
        i_rx        = '0;
        m_state     = S_IDLE;
        m_cmd       = CMD_LFSR;
        m_cnt       = '0;
        m_ack       = 1'b0;
        m_gen       = '0;
        m_local     = '0;
        m_rx        = '0;
        seed_model();
        repeat (4) @(posedge i_clk);
        #1 i_rst_n = 1'b1;

        check_ack(o_ack, 1'b0);
        check_lanes("o_rx", o_rx, '0);
        check_lanes("o_local", o_local, '0);
        repeat (20) tick();
        report("reset and idle pass-through");
        run_cmd(CMD_LFSR, 75, 0);
        report("LFSR generation");
        run_cmd(CMD_DESCRAMBLE, 75, 0);
        report("descramble");
        run_cmd(CMD_LFSR, 100, 0);
        report("LFSR reseed after descramble");
        run_cmd(CMD_LANE_ID, 80, 0);
        report("lane ID");
        run_cmd(CMD_DESCRAMBLE, 30, 2 + ($unsigned($random(seed)) % 8));
        report("handshake hold and stalls");

        $display("Tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pd_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module pd_assertions (
    input wire logic i_clk,
    input wire logic i_rst_n,
    input wire logic i_req,
    input wire logic i_ack
);

    // Ack is cleared by the asynchronous reset
    ack_low_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_ack)
        else $error("o_ack high during reset");

    // Request was up at the edge that raised ack
    ack_rise_with_req: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) $rose(i_ack) |-> $past(i_req))
        else $error("o_ack rose without a request");

    // Host drops the request, ack follows one cycle later
    ack_fall_after_req: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) (i_ack && $fell(i_req)) |=> !i_ack)
        else $error("o_ack did not fall after the request dropped");

endmodule

bind pd_sequencer pd_assertions u_assert (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_req   (i_req),
    .i_ack   (o_ack)
);

`default_nettype wire

// ==== pattern_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_detector (
    input  wire logic            i_clk,
    input  wire logic            i_rst_n,
    input  wire logic            i_req,
    input  wire pd_pkg::pd_cmd_e i_cmd,
    input  wire logic            i_beat_en,
    input  wire pd_pkg::lanes_t  i_rx,
    output logic                 o_ack,
    output pd_pkg::lanes_t       o_rx,
    output pd_pkg::lanes_t       o_local
);
    import pd_pkg::*;

    pd_ctrl_t ctrl;
    lanes_t   lfsr_bits;   // Generator MSBs per lane
    lanes_t   id_bits;

    pd_sequencer u_seq (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_req     (i_req),
        .i_beat_en (i_beat_en),
        .i_cmd     (i_cmd),
        .o_ack     (o_ack),
        .o_ctrl    (ctrl)
    );

    lfsr_bank u_lfsr (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ctrl  (ctrl),
        .o_bits  (lfsr_bits)
    );

    lane_id_gen u_id (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ctrl  (ctrl),
        .o_bits  (id_bits)
    );

    pd_datapath u_dp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ctrl      (ctrl),
        .i_rx        (i_rx),
        .i_lfsr_bits (lfsr_bits),
        .i_id_bits   (id_bits),
        .o_rx        (o_rx),
        .o_local     (o_local)
    );

endmodule

`default_nettype wire

// ==== pd_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module pd_datapath (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire pd_pkg::pd_ctrl_t i_ctrl,
    input  wire pd_pkg::lanes_t   i_rx,
    input  wire pd_pkg::lanes_t   i_lfsr_bits,
    input  wire pd_pkg::lanes_t   i_id_bits,
    output pd_pkg::lanes_t        o_rx,
    output pd_pkg::lanes_t        o_local
);
    import pd_pkg::*;

    lanes_t gen_q;       // First stage of the generated pattern
    logic   descr_beat;
    logic   lfsr_beat;
    logic   id_beat;

    assign descr_beat = i_ctrl.beat && (i_ctrl.cmd == CMD_DESCRAMBLE);
    assign lfsr_beat  = i_ctrl.beat && (i_ctrl.cmd == CMD_LFSR);
    assign id_beat    = i_ctrl.beat && (i_ctrl.cmd == CMD_LANE_ID);

    // Receive path, one register deep
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rx <= '0;
        end else if (descr_beat) begin
            o_rx <= i_rx ^ i_lfsr_bits;
        end else begin
            o_rx <= i_rx;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gen_q <= '0;
        end else if (!i_ctrl.busy) begin
            gen_q <= '0;
        end else if (lfsr_beat) begin
            gen_q <= i_lfsr_bits;
        end else if (id_beat) begin
            gen_q <= i_id_bits;
        end
    end

    // Second stage, two cycles after the beat
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_local <= '0;
        end else begin
            o_local <= gen_q;
        end
    end

endmodule

`default_nettype wire

// ==== pd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pd_defs.svh"

module pd_sequencer (
    input  wire logic            i_clk,
    input  wire logic            i_rst_n,
    input  wire logic            i_req,
    input  wire logic            i_beat_en,
    input  wire pd_pkg::pd_cmd_e i_cmd,
    output logic                 o_ack,
    output pd_pkg::pd_ctrl_t     o_ctrl
);
    import pd_pkg::*;

    seq_state_e state_q;
    pd_cmd_e    cmd_q;      // Command latched at accept
    beat_cnt_t  cnt_q;
    beat_cnt_t  limit;
    logic       in_run;
    logic       run_end;    // Completion cycle, not a beat

    always_comb begin
        case (cmd_q)
            CMD_DESCRAMBLE: limit = beat_cnt_t'(`PD_DESCR_BEATS);
            CMD_LANE_ID:    limit = beat_cnt_t'(`PD_ID_BEATS);
            default:        limit = beat_cnt_t'(`PD_LFSR_BEATS);
        endcase
    end

    assign in_run  = (state_q == S_RUN);
    assign run_end = in_run && i_beat_en && (cnt_q == limit);

    always_comb begin
        o_ctrl.busy   = (state_q == S_SEED) || in_run;
        o_ctrl.reseed = (state_q == S_SEED) || run_end;  // Seeds again at the end
        o_ctrl.beat   = in_run && i_beat_en && (cnt_q < limit);
        o_ctrl.cmd    = cmd_q;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            cmd_q   <= CMD_LFSR;
            cnt_q   <= '0;
            o_ack   <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (i_req) begin
                        cmd_q   <= i_cmd;
                        state_q <= S_SEED;
                    end
                end
                S_SEED: begin
                    cnt_q   <= '0;
                    state_q <= S_RUN;
                end
                S_RUN: begin
                    if (run_end) begin
                        o_ack   <= 1'b1;
                        state_q <= S_DONE;
                    end else if (o_ctrl.beat) begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                S_DONE: begin
                    // Hold ack until the host drops its request
                    if (!i_req) begin
                        o_ack   <= 1'b0;
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== lane_id_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pd_defs.svh"

module lane_id_gen (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire pd_pkg::pd_ctrl_t i_ctrl,
    output pd_pkg::lanes_t        o_bits
);
    import pd_pkg::*;

    id_idx_t idx_q;

    // Frame, lane number with bit order reversed, frame
    function automatic logic [15:0] lane_id(input int unsigned lane);
        logic [7:0] num;
        logic [7:0] rev;
        num = 8'(lane);
        for (int b = 0; b < 8; b++) begin
            rev[b] = num[7-b];
        end
        return {`PD_ID_FRAME, rev, `PD_ID_FRAME};
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idx_q <= '0;
        end else if (i_ctrl.reseed) begin
            idx_q <= '0;
        end else if (i_ctrl.beat && i_ctrl.cmd == CMD_LANE_ID) begin
            idx_q <= idx_q + 1'b1;  // Wraps after bit 15
        end
    end

    always_comb begin
        logic [15:0] id;
        for (int n = 0; n < `PD_LANES; n++) begin
            id        = lane_id(n);
            o_bits[n] = id[idx_q];
        end
    end

endmodule

`default_nettype wire

// ==== lfsr_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pd_defs.svh"

module lfsr_bank (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire pd_pkg::pd_ctrl_t i_ctrl,
    output pd_pkg::lanes_t        o_bits
);
    import pd_pkg::*;

    localparam lfsr_t SEEDS [`PD_LFSR_N] = '{
        `PD_SEED_0, `PD_SEED_1, `PD_SEED_2, `PD_SEED_3,
        `PD_SEED_4, `PD_SEED_5, `PD_SEED_6, `PD_SEED_7
    };

    lfsr_t lfsr_q [`PD_LFSR_N];
    logic  advance;

    // Only the LFSR and descramble commands step the generators
    assign advance = i_ctrl.beat &&
                     (i_ctrl.cmd == CMD_LFSR || i_ctrl.cmd == CMD_DESCRAMBLE);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `PD_LFSR_N; i++) begin
                lfsr_q[i] <= SEEDS[i];
            end
        end else if (i_ctrl.reseed) begin
            for (int i = 0; i < `PD_LFSR_N; i++) begin
                lfsr_q[i] <= SEEDS[i];
            end
        end else if (advance) begin
            for (int i = 0; i < `PD_LFSR_N; i++) begin
                // Shift up, feedback into bit 0
                lfsr_q[i] <= {lfsr_q[i][`PD_LFSR_W-2:0], ^(lfsr_q[i] & `PD_LFSR_TAPS)};
            end
        end
    end

    // Lane n and lane n+8 share one generator
    always_comb begin
        for (int n = 0; n < `PD_LANES; n++) begin
            o_bits[n] = lfsr_q[n % `PD_LFSR_N][`PD_LFSR_W-1];
        end
    end

endmodule

`default_nettype wire

// ==== pd_pkg.sv ====
`default_nettype none

`include "pd_defs.svh"

package pd_pkg;

    typedef logic [`PD_LANES-1:0]  lanes_t;
    typedef logic [`PD_LFSR_W-1:0] lfsr_t;
    typedef logic [`PD_CNT_W-1:0]  beat_cnt_t;
    typedef logic [3:0]            id_idx_t;   // Bit position within a 16-bit lane ID

    typedef enum logic [1:0] {
        CMD_LFSR,
        CMD_DESCRAMBLE,
        CMD_LANE_ID
    } pd_cmd_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SEED,
        S_RUN,
        S_DONE
    } seq_state_e;

    // Control bundle from the sequencer to the pattern blocks
    typedef struct packed {
        logic    busy;
        logic    reseed;  // Load seeds, clear ID index
        logic    beat;
        pd_cmd_e cmd;
    } pd_ctrl_t;

endpackage

`default_nettype wire

// ==== pd_defs.svh ====
`ifndef PD_DEFS_SVH
`define PD_DEFS_SVH

// Lane and LFSR geometry
`define PD_LANES        16
`define PD_LFSR_W       23
`define PD_LFSR_N       8
`define PD_LFSR_TAPS    23'h508092  // Bits 22, 20, 15, 7, 4, 1

// Per-LFSR seeds, loaded on reset and on every reseed
`define PD_SEED_0       23'h1DBFBC
`define PD_SEED_1       23'h0607BB
`define PD_SEED_2       23'h1EC760
`define PD_SEED_3       23'h18C0DB
`define PD_SEED_4       23'h010F12
`define PD_SEED_5       23'h19CFC9
`define PD_SEED_6       23'h0277CE
`define PD_SEED_7       23'h1BB807

`define PD_LFSR_BEATS   4095
`define PD_DESCR_BEATS  7
`define PD_ID_BEATS     2047
`define PD_ID_FRAME     4'b1010     // Leading and trailing nibble of a lane ID
`define PD_CNT_W        12

`endif
